/* common/bt_link_defs.svh */
`ifndef BT_LINK_DEFS_SVH
`define BT_LINK_DEFS_SVH

// host wire endpoint width
`define BT_WORD_W 16

// clocks per serial bit, register width
`define BT_CPD_W 10

// idle bit times between sent bytes, register width
`define BT_SPACE_W 10

// values loaded at reset
`define BT_DEFAULT_CPD 10'd16
`define BT_DEFAULT_SPACE 10'd2

`endif

/* common/bt_link_pkg.sv */
package bt_link_pkg;

	// command word on ep02
	// only a change to one of these values is acted on
	typedef enum logic [2:0] {
		OP_IDLE      = 3'd0,
		OP_SET_CPD   = 3'd1,
		OP_SET_SPACE = 3'd2,
		OP_SEND      = 3'd3,
		OP_CLEAR     = 3'd4
	} host_op_e;

	// serial receiver
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		// byte offered to link_ctrl
		RX_HAND
	} rx_state_e;

	// serial transmitter
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP,
		// line held high between bytes
		TX_GAP
	} tx_state_e;

endpackage

/* common/rx_byte_if.sv */
`timescale 1ns/10ps

// received byte path, four-phase req/ack
interface rx_byte_if;
	// raised by the receiver with data and frame_err stable
	logic       req;
	// raised by the consumer once it has the byte
	logic       ack;
	logic [7:0] data;
	// stop bit sampled low, or an earlier byte was lost
	logic       frame_err;

	// receiver side
	modport source (
		output req,
		output data,
		output frame_err,
		input  ack
	);

	// consumer side
	modport sink (
		input  req,
		input  data,
		input  frame_err,
		output ack
	);
endinterface

/* hw/uart_rx.sv */
`timescale 1ns/10ps
`include "bt_link_defs.svh"

module uart_rx
	import bt_link_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 rxd,
	input  logic [`BT_CPD_W-1:0] cpd,
	rx_byte_if.source            rx
);
	rx_state_e state;
	logic rxd_meta, rxd_sync, rxd_last;
	logic [`BT_CPD_W-1:0] cnt, cnt_nxt;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic overrun;
	logic half_tick, bit_tick, stop_tick;

	assign cnt_nxt = cnt + 1'b1;
	// middle of the start bit
	assign half_tick = (state == RX_START) && (cnt_nxt >= (cpd >> 1));
	// middle of each later bit
	assign bit_tick = (state == RX_DATA) && (cnt_nxt >= cpd);
	assign stop_tick = (state == RX_STOP) && (cnt_nxt >= cpd);

	always_ff @(posedge clock) begin
		if (reset) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_last <= 1'b1;
			state <= RX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			overrun <= 1'b0;
			rx.req <= 1'b0;
			rx.frame_err <= 1'b0;
		end else begin
			// two flop synchronizer, third flop for edge detect
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_last <= rxd_sync;
			cnt <= (half_tick || bit_tick || stop_tick) ? '0 : cnt_nxt;
			case (state)
				RX_IDLE: begin
					cnt <= '0;
					// falling edge starts a frame
					if (rxd_last && !rxd_sync)
						state <= RX_START;
				end
				RX_START: begin
					bit_idx <= '0;
					// line back high at mid start bit means a glitch
					if (half_tick)
						state <= rxd_sync ? RX_IDLE : RX_DATA;
				end
				RX_DATA: begin
					if (bit_tick) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (stop_tick) begin
						if (rx.ack) begin
							// previous byte still open, this one is lost
							overrun <= 1'b1;
							state <= RX_IDLE;
						end else begin
							rx.req <= 1'b1;
							rx.frame_err <= !rxd_sync || overrun;
							overrun <= 1'b0;
							state <= RX_HAND;
						end
					end
				end
				RX_HAND: begin
					// drop req on ack, ack falls while next start bit is awaited
					if (rx.ack) begin
						rx.req <= 1'b0;
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data bits arrive LSB first
	always_ff @(posedge clock) begin
		if (bit_tick)
			shift <= {rxd_sync, shift[7:1]};
		if (stop_tick && !rx.ack)
			rx.data <= shift;
	end
endmodule

/* hw/uart_tx.sv */
`timescale 1ns/10ps
`include "bt_link_defs.svh"

module uart_tx
	import bt_link_pkg::*;
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`BT_CPD_W-1:0]   cpd,
	input  logic [`BT_SPACE_W-1:0] spacing,
	input  logic                   tx_req,
	input  logic [7:0]             tx_data,
	output logic                   tx_ack,
	output logic                   txd,
	output logic                   busy
);
	tx_state_e state;
	logic [`BT_CPD_W-1:0] cnt;
	logic [`BT_SPACE_W-1:0] gap_idx;
	logic [2:0] bit_idx;
	logic [7:0] shift;
	logic bit_end, load;

	// last clock of a bit time
	assign bit_end = (cnt + 1'b1) >= cpd;
	// new byte only once the previous ack has fallen
	assign load = (state == TX_IDLE) && tx_req && !tx_ack;
	assign busy = (state != TX_IDLE);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= TX_IDLE;
			cnt <= '0;
			gap_idx <= '0;
			bit_idx <= '0;
			tx_ack <= 1'b0;
			txd <= 1'b1;
		end else begin
			cnt <= bit_end ? '0 : cnt + 1'b1;
			// ack falls after the request has fallen
			if (tx_ack && !tx_req)
				tx_ack <= 1'b0;
			case (state)
				TX_IDLE: begin
					cnt <= '0;
					if (load) begin
						tx_ack <= 1'b1;
						txd <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START: begin
					bit_idx <= '0;
					if (bit_end) begin
						txd <= shift[0];
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							txd <= 1'b1;
							state <= TX_STOP;
						end else begin
							// next bit before the shift takes effect
							txd <= shift[1];
						end
					end
				end
				TX_STOP: begin
					gap_idx <= '0;
					if (bit_end)
						state <= TX_GAP;
				end
				TX_GAP: begin
					// spacing whole bit times of idle line
					if (bit_end) begin
						gap_idx <= gap_idx + 1'b1;
						if (gap_idx + 1'b1 >= spacing)
							state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (load)
			shift <= tx_data;
		else if (state == TX_DATA && bit_end)
			shift <= {1'b0, shift[7:1]};
	end
endmodule

/* link/link_regs.sv */
`timescale 1ns/10ps
`include "bt_link_defs.svh"

module link_regs
	import bt_link_pkg::*;
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`BT_WORD_W-1:0]  ep01_wire_in,
	input  logic [`BT_WORD_W-1:0]  ep02_wire_in,
	input  logic                   send_ack,
	output logic [`BT_CPD_W-1:0]   cpd,
	output logic [`BT_SPACE_W-1:0] spacing,
	output logic                   send_req,
	output logic [`BT_WORD_W-1:0]  send_word,
	output logic                   clear_cmd
);
	logic [`BT_WORD_W-1:0] ep02_q, pend_word;
	host_op_e op;
	logic op_valid, op_new, send_pend, launch;

	assign op = host_op_e'(ep02_wire_in[2:0]);
	// upper bits zero and code within the opcode range
	assign op_valid = (ep02_wire_in[`BT_WORD_W-1:3] == '0) && (ep02_wire_in[2:0] <= OP_CLEAR);
	// act once per change of the command word
	assign op_new = op_valid && (ep02_wire_in != ep02_q);
	// start a handshake only when the last one is fully closed
	assign launch = send_pend && !send_req && !send_ack;

	always_ff @(posedge clock) begin
		if (reset) begin
			ep02_q <= '0;
			cpd <= `BT_DEFAULT_CPD;
			spacing <= `BT_DEFAULT_SPACE;
			send_req <= 1'b0;
			send_pend <= 1'b0;
			clear_cmd <= 1'b0;
		end else begin
			ep02_q <= ep02_wire_in;
			clear_cmd <= 1'b0;
			if (send_req && send_ack)
				send_req <= 1'b0;
			else if (launch) begin
				send_req <= 1'b1;
				send_pend <= 1'b0;
			end
			if (op_new) begin
				case (op)
					// zero would stall the serial engines
					OP_SET_CPD:
						if (ep01_wire_in[`BT_CPD_W-1:0] != '0)
							cpd <= ep01_wire_in[`BT_CPD_W-1:0];
					OP_SET_SPACE:
						if (ep01_wire_in[`BT_SPACE_W-1:0] != '0)
							spacing <= ep01_wire_in[`BT_SPACE_W-1:0];
					// queued here while link_ctrl is still busy
					OP_SEND: send_pend <= 1'b1;
					OP_CLEAR: clear_cmd <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (op_new && op == OP_SEND)
			pend_word <= ep01_wire_in;
		if (launch)
			send_word <= pend_word;
	end
endmodule

/* link/link_ctrl.sv */
`timescale 1ns/10ps
`include "bt_link_defs.svh"

module link_ctrl (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  bt_state,
	input  logic                  send_req,
	input  logic [`BT_WORD_W-1:0] send_word,
	input  logic                  clear_cmd,
	input  logic                  tx_ack,
	input  logic                  tx_busy,
	rx_byte_if.sink               rx,
	output logic                  send_ack,
	output logic                  tx_req,
	output logic [7:0]            tx_data,
	output logic [`BT_WORD_W-1:0] rx_word,
	output logic [`BT_WORD_W-1:0] rx_count,
	output logic [`BT_WORD_W-1:0] tx_count,
	output logic [`BT_WORD_W-1:0] status
);
	// send sequencer, high byte then low byte
	typedef enum logic [1:0] {SEQ_IDLE, SEQ_HI, SEQ_LO, SEQ_DONE} seq_state_e;

	seq_state_e seq;
	logic bt_meta, bt_sync;
	logic [7:0] hi_byte, lo_byte;
	logic have_hi, frame_sticky, refused;
	logic byte_take, accept, lo_launch;

	// req and ack both high for exactly one cycle per byte
	assign byte_take = rx.req && rx.ack;
	assign accept = (seq == SEQ_IDLE) && send_req && !send_ack;
	assign lo_launch = (seq == SEQ_LO) && !tx_req && !tx_ack;
	assign status = {{(`BT_WORD_W-5){1'b0}}, refused, have_hi, frame_sticky, tx_busy, bt_sync};

	always_ff @(posedge clock) begin
		if (reset) begin
			rx.ack <= 1'b0;
			have_hi <= 1'b0;
			frame_sticky <= 1'b0;
			rx_word <= '0;
			rx_count <= '0;
		end else begin
			// ack trails req by one cycle on both edges
			rx.ack <= rx.req;
			if (byte_take) begin
				if (rx.frame_err) begin
					// bad byte dropped, pairing restarts
					frame_sticky <= 1'b1;
					have_hi <= 1'b0;
				end else if (!have_hi) begin
					have_hi <= 1'b1;
				end else begin
					rx_word <= {hi_byte, rx.data};
					rx_count <= rx_count + 1'b1;
					have_hi <= 1'b0;
				end
			end
			if (clear_cmd) begin
				rx_count <= '0;
				frame_sticky <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (byte_take && !have_hi)
			hi_byte <= rx.data;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			bt_meta <= 1'b0;
			bt_sync <= 1'b0;
			seq <= SEQ_IDLE;
			send_ack <= 1'b0;
			tx_req <= 1'b0;
			tx_count <= '0;
			refused <= 1'b0;
		end else begin
			bt_meta <= bt_state;
			bt_sync <= bt_meta;
			if (send_ack && !send_req)
				send_ack <= 1'b0;
			case (seq)
				SEQ_IDLE: begin
					if (accept) begin
						send_ack <= 1'b1;
						// disconnected, close the handshake and flag it
						if (bt_sync) begin
							tx_req <= 1'b1;
							seq <= SEQ_HI;
						end else begin
							refused <= 1'b1;
						end
					end
				end
				SEQ_HI: begin
					if (tx_ack) begin
						tx_req <= 1'b0;
						seq <= SEQ_LO;
					end
				end
				SEQ_LO: begin
					// wait for ack low before offering the low byte
					if (lo_launch)
						tx_req <= 1'b1;
					else if (tx_req && tx_ack) begin
						tx_req <= 1'b0;
						seq <= SEQ_DONE;
					end
				end
				SEQ_DONE: begin
					// count after the low byte and its gap
					if (!tx_ack && !tx_busy) begin
						tx_count <= tx_count + 1'b1;
						seq <= SEQ_IDLE;
					end
				end
				default: seq <= SEQ_IDLE;
			endcase
			if (clear_cmd) begin
				tx_count <= '0;
				refused <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			tx_data <= send_word[15:8];
			lo_byte <= send_word[7:0];
		end else if (lo_launch) begin
			tx_data <= lo_byte;
		end
	end
endmodule

/* hw/bt_link_top.sv */
`timescale 1ns/10ps
`include "bt_link_defs.svh"

module bt_link_top (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  bt_state,
	input  logic                  rxd,
	input  logic [`BT_WORD_W-1:0] ep01_wire_in,
	input  logic [`BT_WORD_W-1:0] ep02_wire_in,
	output logic                  txd,
	output logic [`BT_WORD_W-1:0] ep20_wire_out,
	output logic [`BT_WORD_W-1:0] ep21_wire_out,
	output logic [`BT_WORD_W-1:0] ep22_wire_out,
	output logic [`BT_WORD_W-1:0] ep23_wire_out,
	output logic [`BT_WORD_W-1:0] ep24_wire_out,
	output logic [`BT_WORD_W-1:0] ep25_wire_out
);
	logic [`BT_CPD_W-1:0] cpd;
	logic [`BT_SPACE_W-1:0] spacing;
	logic send_req, send_ack, clear_cmd;
	logic [`BT_WORD_W-1:0] send_word;
	logic tx_req, tx_ack, tx_busy;
	logic [7:0] tx_data;

	// receiver to link_ctrl
	rx_byte_if rx_bus ();

	uart_rx u_rx (
		.clock(clock),
		.reset(reset),
		.rxd(rxd),
		.cpd(cpd),
		.rx(rx_bus)
	);

	uart_tx u_tx (
		.clock(clock),
		.reset(reset),
		.cpd(cpd),
		.spacing(spacing),
		.tx_req(tx_req),
		.tx_data(tx_data),
		.tx_ack(tx_ack),
		.txd(txd),
		.busy(tx_busy)
	);

	link_regs u_regs (
		.clock(clock),
		.reset(reset),
		.ep01_wire_in(ep01_wire_in),
		.ep02_wire_in(ep02_wire_in),
		.send_ack(send_ack),
		.cpd(cpd),
		.spacing(spacing),
		.send_req(send_req),
		.send_word(send_word),
		.clear_cmd(clear_cmd)
	);

	// word, counts and status go straight to their endpoints
	link_ctrl u_ctrl (
		.clock(clock),
		.reset(reset),
		.bt_state(bt_state),
		.send_req(send_req),
		.send_word(send_word),
		.clear_cmd(clear_cmd),
		.tx_ack(tx_ack),
		.tx_busy(tx_busy),
		.rx(rx_bus),
		.send_ack(send_ack),
		.tx_req(tx_req),
		.tx_data(tx_data),
		.rx_word(ep20_wire_out),
		.rx_count(ep21_wire_out),
		.tx_count(ep25_wire_out),
		.status(ep22_wire_out)
	);

	// configuration readback, zero extended
	assign ep23_wire_out = {{(`BT_WORD_W-`BT_CPD_W){1'b0}}, cpd};
	assign ep24_wire_out = {{(`BT_WORD_W-`BT_SPACE_W){1'b0}}, spacing};
endmodule

/* verif/bt_link_properties.sv */
`timescale 1ns/10ps

module bt_link_properties (
	input logic clock,
	input logic reset,
	input logic rx_req,
	input logic rx_ack,
	input logic send_req,
	input logic send_ack
);
	// byte offer held until taken
	rx_req_held: assert property (@(posedge clock) disable iff (reset)
		rx_req && !rx_ack |=> rx_req)
		else $error("rx req dropped before ack");

	// send request held until taken
	send_req_held: assert property (@(posedge clock) disable iff (reset)
		send_req && !send_ack |=> send_req)
		else $error("send req dropped before send ack");

	// no ack without a pending request
	rx_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
		$rose(rx_ack) |-> rx_req)
		else $error("rx ack rose with req low");

	// send ack rises only on a request
	send_ack_rise: assert property (@(posedge clock) disable iff (reset)
		$rose(send_ack) |-> send_req)
		else $error("send ack rose with send req low");
	// no new request before the ack has fallen
	send_req_wait: assert property (@(posedge clock) disable iff (reset)
		send_ack && !send_req |=> !send_req)
		else $error("send req rose again before send ack fell");
endmodule

bind link_ctrl bt_link_properties u_props (
	.clock(clock),
	.reset(reset),
	.rx_req(rx.req),
	.rx_ack(rx.ack),
	.send_req(send_req),
	.send_ack(send_ack)
);

/* verif/bt_link_tb.sv */
`timescale 1ns/10ps
`include "bt_link_defs.svh"

module bt_link_tb
	import bt_link_pkg::*;
();
	// status bit positions on ep22
	localparam int ST_LINK = 0;
	localparam int ST_BUSY = 1;
	localparam int ST_FRAME = 2;
	localparam int ST_HALF = 3;
	localparam int ST_REFUSED = 4;
	// configuration under test
	localparam int NEW_CPD = 12;
	localparam int NEW_SPACE = 3;
	localparam int RX_PAIRS = 4;
	// run length in bit times
	// each rx byte is a 10 bit frame and 2 idle bits
	localparam int CONFIG_BITS = 8;
	localparam int RX_BITS = (2 * RX_PAIRS + 2) * 12;
	localparam int TX_BITS = 2 * (10 + NEW_SPACE) + 20 + 40;
	localparam int CLEAR_BITS = 4;
	localparam int RUN_BITS = CONFIG_BITS + RX_BITS + TX_BITS + CLEAR_BITS;
	// slowest cpd seen by any test is the reset default
	localparam int WATCHDOG_NS = RUN_BITS * 16 * 10 + 20000;

	logic clock;
	logic reset;
	logic bt_state;
	logic rxd;
	logic [`BT_WORD_W-1:0] ep01_wire_in;
	logic [`BT_WORD_W-1:0] ep02_wire_in;
	logic txd;
	logic [`BT_WORD_W-1:0] ep20_wire_out;
	logic [`BT_WORD_W-1:0] ep21_wire_out;
	logic [`BT_WORD_W-1:0] ep22_wire_out;
	logic [`BT_WORD_W-1:0] ep23_wire_out;
	logic [`BT_WORD_W-1:0] ep24_wire_out;
	logic [`BT_WORD_W-1:0] ep25_wire_out;

	integer seed;
	int mismatches;
	int faults;
	// tb model of the link configuration
	int exp_cpd;
	int exp_space;

	bt_link_top uut (
		.clock(clock),
		.reset(reset),
		.bt_state(bt_state),
		.rxd(rxd),
		.ep01_wire_in(ep01_wire_in),
		.ep02_wire_in(ep02_wire_in),
		.txd(txd),
		.ep20_wire_out(ep20_wire_out),
		.ep21_wire_out(ep21_wire_out),
		.ep22_wire_out(ep22_wire_out),
		.ep23_wire_out(ep23_wire_out),
		.ep24_wire_out(ep24_wire_out),
		.ep25_wire_out(ep25_wire_out)
	);

	always #5 clock = ~clock;

	task automatic check_word(input string name, input logic [`BT_WORD_W-1:0] exp,
			input logic [`BT_WORD_W-1:0] act);
		if (exp !== act) begin
			mismatches++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			mismatches++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			mismatches++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	function automatic logic [`BT_WORD_W-1:0] endpoint_value(input int sel);
		case (sel)
			'h20: return ep20_wire_out;
			'h21: return ep21_wire_out;
			'h22: return ep22_wire_out;
			default: return ep25_wire_out;
		endcase
	endfunction

	// poll an output endpoint at the falling edge until the masked value matches
	task automatic wait_for(input string what, input int sel, input logic [`BT_WORD_W-1:0] mask,
			input logic [`BT_WORD_W-1:0] value, input int limit);
		int n;
		n = 0;
		@(negedge clock);
		while (((endpoint_value(sel) & mask) !== value) && n < limit) begin
			n++;
			@(negedge clock);
		end
		if ((endpoint_value(sel) & mask) !== value) begin
			faults++;
			$display("timeout waiting for %s", what);
		end
	endtask

	task automatic random_byte(output logic [7:0] b);
		int r;
		r = $random(seed);
		b = r[7:0];
	endtask

	// raw command word on ep02
	task automatic host_raw(input logic [`BT_WORD_W-1:0] cmd, input logic [`BT_WORD_W-1:0] arg);
		@(posedge clock);
		ep01_wire_in <= arg;
		ep02_wire_in <= cmd;
		repeat (3) @(posedge clock);
		// back to idle so the next one is a change
		ep02_wire_in <= `BT_WORD_W'(OP_IDLE);
		repeat (2) @(posedge clock);
	endtask

	task automatic host_cmd(input host_op_e op, input logic [`BT_WORD_W-1:0] arg);
		host_raw(`BT_WORD_W'(op), arg);
	endtask

	// 8N1 frame on rxd with an optional low stop bit
	task automatic drive_rx_byte(input logic [7:0] b, input logic bad_stop);
		int i;
		@(posedge clock);
		rxd <= 1'b0;
		repeat (exp_cpd) @(posedge clock);
		for (i = 0; i < 8; i++) begin
			rxd <= b[i];
			repeat (exp_cpd) @(posedge clock);
		end
		rxd <= !bad_stop;
		repeat (exp_cpd) @(posedge clock);
		// two idle bit times
		rxd <= 1'b1;
		repeat (2 * exp_cpd) @(posedge clock);
	endtask

	// decode one frame from txd
	// idle counts high clocks before the start bit
	// returns on the last clock of the stop bit
	task automatic read_tx_byte(output logic [7:0] b, output int idle, input int limit);
		int i;
		idle = 0;
		b = '0;
		@(negedge clock);
		while (txd && idle < limit) begin
			idle++;
			@(negedge clock);
		end
		if (txd) begin
			faults++;
			$display("timeout waiting for a start bit on txd");
		end else begin
			repeat (exp_cpd / 2) @(negedge clock);
			if (txd) begin
				faults++;
				$display("start bit on txd ended before mid-bit");
			end
			for (i = 0; i < 8; i++) begin
				repeat (exp_cpd) @(negedge clock);
				b[i] = txd;
			end
			repeat (exp_cpd) @(negedge clock);
			if (!txd) begin
				faults++;
				$display("stop bit on txd was low");
			end
			repeat (exp_cpd - exp_cpd / 2 - 1) @(negedge clock);
		end
	endtask

	// txd must stay high for the whole window
	task automatic watch_line_idle(input int cycles);
		int n;
		logic went_low;
		went_low = 1'b0;
		for (n = 0; n < cycles; n++) begin
			@(negedge clock);
			if (!txd)
				went_low = 1'b1;
		end
		if (went_low) begin
			faults++;
			$display("txd went low during a send while disconnected");
		end
	endtask

	task automatic test_reset_values();
		@(negedge clock);
		check_bit("txd", 1'b1, txd);
		check_word("ep20_wire_out", '0, ep20_wire_out);
		check_word("ep21_wire_out", '0, ep21_wire_out);
		check_word("ep22_wire_out", '0, ep22_wire_out);
		check_word("ep25_wire_out", '0, ep25_wire_out);
		check_word("ep23_wire_out", `BT_WORD_W'(`BT_DEFAULT_CPD), ep23_wire_out);
		check_word("ep24_wire_out", `BT_WORD_W'(`BT_DEFAULT_SPACE), ep24_wire_out);
	endtask

	task automatic test_config();
		host_cmd(OP_SET_CPD, `BT_WORD_W'(NEW_CPD));
		@(negedge clock);
		check_word("ep23_wire_out", `BT_WORD_W'(NEW_CPD), ep23_wire_out);
		host_cmd(OP_SET_SPACE, `BT_WORD_W'(NEW_SPACE));
		@(negedge clock);
		check_word("ep24_wire_out", `BT_WORD_W'(NEW_SPACE), ep24_wire_out);
		// zero values ignored
		host_cmd(OP_SET_CPD, '0);
		host_cmd(OP_SET_SPACE, '0);
		// code out of range
		host_raw(16'h0006, 16'h0005);
		// upper bits set on a valid low code
		host_raw(16'h0009, 16'h0005);
		@(negedge clock);
		check_word("ep23_wire_out", `BT_WORD_W'(NEW_CPD), ep23_wire_out);
		check_word("ep24_wire_out", `BT_WORD_W'(NEW_SPACE), ep24_wire_out);
		exp_cpd = NEW_CPD;
		exp_space = NEW_SPACE;
	endtask

	task automatic test_receive();
		logic [7:0] hi;
		logic [7:0] lo;
		logic [`BT_WORD_W-1:0] count;
		int p;
		count = '0;
		for (p = 0; p < RX_PAIRS; p++) begin
			random_byte(hi);
			random_byte(lo);
			drive_rx_byte(hi, 1'b0);
			drive_rx_byte(lo, 1'b0);
			count++;
			wait_for("received half-word count", 'h21, '1, count, 4 * exp_cpd);
			check_word("ep20_wire_out", {hi, lo}, ep20_wire_out);
			check_word("ep21_wire_out", count, ep21_wire_out);
			check_bit("ep22_wire_out[3]", 1'b0, ep22_wire_out[ST_HALF]);
		end
		// single byte stays held
		random_byte(hi);
		drive_rx_byte(hi, 1'b0);
		wait_for("held byte flag", 'h22, 1 << ST_HALF, 1 << ST_HALF, 4 * exp_cpd);
		check_bit("ep22_wire_out[3]", 1'b1, ep22_wire_out[ST_HALF]);
		check_word("ep21_wire_out", count, ep21_wire_out);
	endtask

	task automatic test_send();
		logic [`BT_WORD_W-1:0] word;
		logic [7:0] hi;
		logic [7:0] lo;
		int idle;
		int gap;
		@(posedge clock);
		bt_state <= 1'b1;
		repeat (4) @(posedge clock);
		random_byte(word[15:8]);
		random_byte(word[7:0]);
		fork
			host_cmd(OP_SEND, word);
			begin
				read_tx_byte(hi, idle, 40 * exp_cpd);
				read_tx_byte(lo, gap, 40 * exp_cpd);
			end
		join
		// low byte still in its stop bit
		check_bit("ep22_wire_out[1]", 1'b1, ep22_wire_out[ST_BUSY]);
		check_byte("txd high byte", word[15:8], hi);
		check_byte("txd low byte", word[7:0], lo);
		if (gap < exp_space * exp_cpd) begin
			mismatches++;
			$display("Fail txd idle gap expected >= %h actual %h", exp_space * exp_cpd, gap);
		end
		wait_for("sent half-word count", 'h25, '1, 16'd1, (exp_space + 2) * exp_cpd);
		check_word("ep25_wire_out", 16'd1, ep25_wire_out);
		check_bit("ep22_wire_out[1]", 1'b0, ep22_wire_out[ST_BUSY]);
		check_bit("ep22_wire_out[0]", 1'b1, ep22_wire_out[ST_LINK]);

		// send refused while disconnected
		@(posedge clock);
		bt_state <= 1'b0;
		repeat (4) @(posedge clock);
		random_byte(word[15:8]);
		fork
			host_cmd(OP_SEND, word);
			watch_line_idle(20 * exp_cpd);
		join
		check_word("ep25_wire_out", 16'd1, ep25_wire_out);
		wait_for("refused send flag", 'h22, 1 << ST_REFUSED, 1 << ST_REFUSED, 8);
		check_bit("ep22_wire_out[4]", 1'b1, ep22_wire_out[ST_REFUSED]);
	endtask

	task automatic test_frame_and_clear();
		logic [`BT_WORD_W-1:0] word_before;
		logic [`BT_WORD_W-1:0] count_before;
		logic [7:0] b;
		@(negedge clock);
		word_before = ep20_wire_out;
		count_before = ep21_wire_out;
		random_byte(b);
		drive_rx_byte(b, 1'b1);
		wait_for("framing error flag", 'h22, 1 << ST_FRAME, 1 << ST_FRAME, 4 * exp_cpd);
		check_bit("ep22_wire_out[2]", 1'b1, ep22_wire_out[ST_FRAME]);
		// bad byte also drops the held first byte
		check_bit("ep22_wire_out[3]", 1'b0, ep22_wire_out[ST_HALF]);
		check_word("ep20_wire_out", word_before, ep20_wire_out);
		check_word("ep21_wire_out", count_before, ep21_wire_out);
		host_cmd(OP_CLEAR, '0);
		@(negedge clock);
		check_word("ep21_wire_out", '0, ep21_wire_out);
		check_word("ep25_wire_out", '0, ep25_wire_out);
		check_bit("ep22_wire_out[2]", 1'b0, ep22_wire_out[ST_FRAME]);
		check_bit("ep22_wire_out[4]", 1'b0, ep22_wire_out[ST_REFUSED]);
	endtask

	// hard stop sized from the bit budget of all tests
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		bt_state = 1'b0;
		rxd = 1'b1;
		ep01_wire_in = '0;
		ep02_wire_in = '0;
		seed = 35169;
		mismatches = 0;
		faults = 0;
		exp_cpd = `BT_DEFAULT_CPD;
		exp_space = `BT_DEFAULT_SPACE;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		test_reset_values();
		test_config();
		test_receive();
		test_send();
		test_frame_and_clear();
		$display("errors: %0d value mismatches, %0d timeouts or protocol faults",
			mismatches, faults);
		if (mismatches + faults == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end
endmodule

/* bt_link.f */
+incdir+common
common/bt_link_pkg.sv
common/rx_byte_if.sv
hw/uart_rx.sv
hw/uart_tx.sv
link/link_regs.sv
link/link_ctrl.sv
hw/bt_link_top.sv
verif/bt_link_properties.sv
verif/bt_link_tb.sv

/* Makefile */
TOP = bt_link_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal -f bt_link.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
